// File: dv/dadda_cases.txt
zero_zero 0000 0000 00000000
zero_ones 0000 ffff 00000000
ones_zero ffff 0000 00000000
one_one 0001 0001 00000001
one_ones 0001 ffff 0000ffff
ones_one ffff 0001 0000ffff
ones_ones ffff ffff fffe0001
msb_msb 8000 8000 40000000
msb_ones 8000 ffff 7fff8000
ones_msb ffff 8000 7fff8000
bit1_bit14 0002 4000 00008000
bit7_bit8 0080 0100 00008000
bit15_bit1 8000 0002 00010000
bit3_bit12 0008 1000 00008000
bit0_bit15 0001 8000 00008000
bit1_bit1 0002 0002 00000004
bit14_bit14 4000 4000 10000000
bit8_bit8 0100 0100 00010000
alt_5555_5555 5555 5555 1c718e39
alt_aaaa_aaaa aaaa aaaa 71c638e4
alt_5555_aaaa 5555 aaaa 38e31c72
alt_aaaa_5555 aaaa 5555 38e31c72
ones_5555 ffff 5555 5554aaab
aaaa_ones aaaa ffff aaa95556
ff00_00ff ff00 00ff 00fe0100
lowbyte_sq 00ff 00ff 0000fe01
highbyte_sq ff00 ff00 fe010000
nibble_0f0f_f0f0 0f0f f0f0 0e2c2e10
nibble_f0f0_0f0f f0f0 0f0f 0e2c2e10
ones_8001 ffff 8001 80007fff
mixed_1234_5678 1234 5678 06260060
max_pos_sq 7fff 7fff 3fff0001
ends_8001_sq 8001 8001 40010001
fffe_fffe fffe fffe fffc0004
ffff_fffe ffff fffe fffd0002
three_three 0003 0003 00000009
nibble_sq 000f 000f 000000e1
lowbyte_ones 00ff ffff 00feff01
ones_lowbyte ffff 00ff 00feff01
repeat_1111 1111 1111 01234321
twelve_bit_sq 0fff 0fff 00ffe001

// File: dadda_mult.f
+incdir+design
design/dadda_pkg.sv
design/dadda_stage.sv
design/dadda_tree.sv
design/brent_kung_adder.sv
design/pipe_stage.sv
design/dadda_mult.sv
dv/dadda_mult_sva.sv
dv/dadda_mult_tb.sv

// File: dv/dadda_mult_tb.sv
`timescale 1ns/1ps
`include "dadda_consts.svh"

module dadda_mult_tb import dadda_pkg::*; ();

  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = 50;
  localparam logic [31:0] SEED  = 32'h4385f5da;

  logic     clk;
  logic     arst_n;
  logic     in_valid;
  logic     in_ready;
  operand_t a;
  operand_t b;
  logic     out_valid;
  logic     out_ready;
  product_t product;

  // what the producer is offering this cycle
  product_t drive_expected;
  string    drive_name;

  // back-pressure source
  logic        ready_random;
  logic [31:0] bp_state;
  logic [31:0] op_state;

  // scoreboard in acceptance order
  product_t expected_q[$];
  string    name_q[$];
  int       accept_cycle_q[$];
  int       cycle_count;
  logic     check_latency;

  // directed cases from the file
  string    case_name[$];
  operand_t case_a[$];
  operand_t case_b[$];
  product_t case_product[$];

  dadda_mult dut_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .a        (a),
    .b        (b),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .product  (product)
  );

  bind dadda_mult dadda_mult_sva sva_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .product  (product)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] s;
    s = state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      fail_run($sformatf("FAIL %s expected %h actual %h", test_name, expected, actual));
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          fields;
    string       name;
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] vp;
    fd = $fopen("dv/dadda_cases.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the directed case file dv/dadda_cases.txt");
    end
    while (!$feof(fd)) begin
      fields = $fscanf(fd, "%s %h %h %h\n", name, va, vb, vp);
      if (fields == 4) begin
        case_name.push_back(name);
        case_a.push_back(va[15:0]);
        case_b.push_back(vb[15:0]);
        case_product.push_back(vp);
      end
    end
    $fclose(fd);
    if (case_name.size() == 0) begin
      fail_run("the directed case file held no cases");
    end
  endtask

  // called on a falling edge and returns on the falling edge after the transfer
  task automatic send_pair(input string name, input operand_t op_a, input operand_t op_b,
                           input product_t expected);
    int   waited;
    logic taken;
    in_valid       = 1'b1;
    a              = op_a;
    b              = op_b;
    drive_expected = expected;
    drive_name     = name;
    waited         = 0;
    do begin
      @(posedge clk);
      taken  = in_ready;
      waited = waited + 1;
      if (!taken && waited >= TIMEOUT_CYCLES) begin
        fail_run($sformatf("the DUT never accepted input %s", name));
      end
    end while (!taken);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk);
      waited = waited + 1;
      if (waited > TIMEOUT_CYCLES) begin
        fail_run("the DUT never delivered the pending products");
      end
    end
  endtask

  task automatic hold_ready(input logic level);
    @(posedge clk);
    ready_random = 1'b0;
    @(negedge clk);
    out_ready = level;
  endtask

  task automatic randomize_ready();
    @(posedge clk);
    ready_random = 1'b1;
    @(negedge clk);
  endtask

  always @(negedge clk) begin
    if (ready_random) begin
      bp_state  = xorshift32(bp_state);
      out_ready = bp_state[7];
    end
  end

  // scoreboard sampled on the rising edge
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (arst_n) begin
      if (out_valid && out_ready) begin
        if (expected_q.size() == 0) begin
          fail_run("the DUT delivered a product that was never requested");
        end else begin
          check_value(name_q[0], expected_q[0], product);
          if (check_latency) begin
            check_value({name_q[0], " latency"}, 32'd2, cycle_count - accept_cycle_q[0]);
          end
          void'(expected_q.pop_front());
          void'(name_q.pop_front());
          void'(accept_cycle_q.pop_front());
        end
      end
      if (in_valid && in_ready) begin
        expected_q.push_back(drive_expected);
        name_q.push_back(drive_name);
        accept_cycle_q.push_back(cycle_count);
      end
    end
  end

  initial begin
    operand_t ra;
    operand_t rb;
    int       pick;
    arst_n         = 1'b0;
    in_valid       = 1'b0;
    a              = '0;
    b              = '0;
    out_ready      = 1'b1;
    ready_random   = 1'b0;
    check_latency  = 1'b0;
    cycle_count    = 0;
    drive_expected = '0;
    drive_name     = "";
    op_state       = SEED;
    bp_state       = SEED ^ 32'h9e3779b9;

    load_cases();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    check_value("reset_in_ready", 32'd1, {31'd0, in_ready});
    check_value("reset_out_valid", 32'd0, {31'd0, out_valid});

    for (int i = 0; i < case_name.size(); i++) begin
      send_pair(case_name[i], case_a[i], case_b[i], case_product[i]);
    end
    drain_pipeline();

    // back to back with a fixed two cycle latency
    check_latency = 1'b1;
    for (int i = 0; i < 200; i++) begin
      op_state = xorshift32(op_state);
      ra       = op_state[15:0];
      rb       = op_state[31:16];
      send_pair("random_stream", ra, rb, product_t'(ra) * product_t'(rb));
    end
    drain_pipeline();
    check_latency = 1'b0;

    randomize_ready();
    for (int i = 0; i < 300; i++) begin
      op_state = xorshift32(op_state);
      ra       = op_state[15:0];
      rb       = op_state[31:16];
      send_pair("random_backpressure", ra, rb, product_t'(ra) * product_t'(rb));
    end
    drain_pipeline();

    // fill both slots and reset in the middle
    hold_ready(1'b0);
    send_pair("stalled_first", 16'h1234, 16'h5678, 32'h06260060);
    send_pair("stalled_second", 16'hffff, 16'hffff, 32'hfffe0001);
    check_value("midstream_out_valid", 32'd1, {31'd0, out_valid});
    check_value("midstream_in_ready", 32'd0, {31'd0, in_ready});
    arst_n = 1'b0;
    #1;
    check_value("reset_drops_out_valid", 32'd0, {31'd0, out_valid});
    expected_q.delete();
    name_q.delete();
    accept_cycle_q.delete();
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n    = 1'b1;
    out_ready = 1'b1;

    pick = -1;
    for (int i = 0; i < case_name.size(); i++) begin
      if (case_name[i] == "ones_ones") begin
        pick = i;
      end
    end
    if (pick < 0) begin
      fail_run("the directed case ones_ones is missing from the case file");
    end
    send_pair("after_reset", case_a[pick], case_b[pick], case_product[pick]);
    drain_pipeline();

    $display("Test passed");
    $finish;
  end

endmodule

// File: dv/dadda_mult_sva.sv
`timescale 1ns/1ps

module dadda_mult_sva import dadda_pkg::*; (
  input logic     clk,
  input logic     arst_n,
  input logic     in_valid,
  input logic     in_ready,
  input logic     out_valid,
  input logic     out_ready,
  input product_t product
);

  // set by the first accepted input after reset
  logic seen_input;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seen_input <= 1'b0;
    end else if (in_valid && in_ready) begin
      seen_input <= 1'b1;
    end
  end

  a_idle_after_reset: assert property (
    @(posedge clk) disable iff (!arst_n) !seen_input |-> !out_valid
  ) else $error("out_valid rose before any input was accepted");

  a_hold_when_stalled: assert property (
    @(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(product)
  ) else $error("product or out_valid changed while stalled");

  a_ready_passes_back: assert property (
    @(posedge clk) disable iff (!arst_n) out_ready |-> in_ready
  ) else $error("in_ready low while out_ready high");

  a_product_known: assert property (
    @(posedge clk) disable iff (!arst_n) out_valid |-> !$isunknown(product)
  ) else $error("product has unknown bits while out_valid high");

endmodule

// File: design/dadda_mult.sv
`timescale 1ns/1ps
`include "dadda_consts.svh"

module dadda_mult import dadda_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  operand_t a,
  input  operand_t b,
  output logic     out_valid,
  input  logic     out_ready,
  output product_t product
);

  rows_t    tree_rows;
  rows_t    held_rows;
  logic     rows_valid;
  logic     rows_ready;
  product_t row_sum;

  // partial products and reduction, combinational
  dadda_tree tree_i (
    .a   (a),
    .b   (b),
    .rows(tree_rows)
  );

  pipe_stage #(
    .payload_t(rows_t)
  ) rows_slot (
    .clk       (clk),
    .arst_n    (arst_n),
    .up_valid  (in_valid),
    .up_ready  (in_ready),
    .up_data   (tree_rows),
    .down_valid(rows_valid),
    .down_ready(rows_ready),
    .down_data (held_rows)
  );

  brent_kung_adder #(
    .WIDTH(`DADDA_PROD_W)
  ) adder_i (
    .x  (held_rows.sum_row),
    .y  (held_rows.carry_row),
    .sum(row_sum)
  );

  pipe_stage #(
    .payload_t(product_t)
  ) product_slot (
    .clk       (clk),
    .arst_n    (arst_n),
    .up_valid  (rows_valid),
    .up_ready  (rows_ready),
    .up_data   (row_sum),
    .down_valid(out_valid),
    .down_ready(out_ready),
    .down_data (product)
  );

endmodule

// File: design/pipe_stage.sv
`timescale 1ns/1ps

module pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     up_valid,
  output logic     up_ready,
  input  payload_t up_data,
  output logic     down_valid,
  input  logic     down_ready,
  output payload_t down_data
);

  // accept when empty or draining this cycle
  assign up_ready = !down_valid || down_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      down_valid <= 1'b0;
    end else if (up_ready) begin
      down_valid <= up_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up_valid && up_ready) begin
      down_data <= up_data;
    end
  end

endmodule

// File: design/brent_kung_adder.sv
`timescale 1ns/1ps

module brent_kung_adder #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0] x,
  input  logic [WIDTH-1:0] y,
  output logic [WIDTH-1:0] sum
);

  localparam int LEVELS = $clog2(WIDTH);

  logic [WIDTH-1:0] bit_g;
  logic [WIDTH-1:0] bit_p;
  logic [WIDTH-1:0] up_g;
  logic [WIDTH-1:0] up_p;
  logic [WIDTH-1:0] prefix_g;

  assign bit_g = x & y;
  assign bit_p = x ^ y;

  // up-sweep
  // after stride d, position i with (i+1) a multiple of 2d holds
  // the group of 2d bits ending at i
  always_comb begin
    up_g = bit_g;
    up_p = bit_p;
    for (int d = 1; d < WIDTH; d = d * 2) begin
      for (int i = 2 * d - 1; i < WIDTH; i = i + 2 * d) begin
        up_g[i] = up_g[i] | (up_p[i] & up_g[i-d]);
        up_p[i] = up_p[i] & up_p[i-d];
      end
    end
  end

  // down-sweep
  // fills the remaining positions from the nearest complete prefix below
  always_comb begin
    prefix_g = up_g;
    for (int d = 2 ** (LEVELS - 1); d > 0; d = d / 2) begin
      for (int i = 3 * d - 1; i < WIDTH; i = i + 2 * d) begin
        prefix_g[i] = prefix_g[i] | (up_p[i] & prefix_g[i-d]);
      end
    end
  end

  // carry into bit i is the prefix generate of bits below it
  // no carry-in, the msb carry-out is dropped
  assign sum = bit_p ^ {prefix_g[WIDTH-2:0], 1'b0};

endmodule

// File: design/dadda_tree.sv
`timescale 1ns/1ps
`include "dadda_consts.svh"

module dadda_tree import dadda_pkg::*; (
  input  operand_t a,
  input  operand_t b,
  output rows_t    rows
);

  localparam int NUM_STAGES = `DADDA_NUM_STAGES;
  localparam int HEIGHTS [NUM_STAGES] = '{
    `DADDA_HEIGHT_1,
    `DADDA_HEIGHT_2,
    `DADDA_HEIGHT_3,
    `DADDA_HEIGHT_4,
    `DADDA_HEIGHT_5,
    `DADDA_HEIGHT_6
  };

  col_matrix_t pp_cols;
  col_matrix_t layer_cols [NUM_STAGES+1];

  // a[i] & b[j] goes to column i+j, packed to the bottom
  always_comb begin
    int row;
    pp_cols = '0;
    for (int i = 0; i < `DADDA_OP_W; i++) begin
      for (int j = 0; j < `DADDA_OP_W; j++) begin
        row = (i + j < `DADDA_OP_W) ? j : `DADDA_OP_W - 1 - i;
        pp_cols[i+j][row] = a[i] & b[j];
      end
    end
  end

  assign layer_cols[0] = pp_cols;

  for (genvar s = 0; s < NUM_STAGES; s++) begin : g_layer
    dadda_stage #(
      .TARGET_HEIGHT(HEIGHTS[s])
    ) layer_i (
      .cols_in (layer_cols[s]),
      .cols_out(layer_cols[s+1])
    );
  end

  // two bits left per column
  always_comb begin
    for (int c = 0; c < `DADDA_PROD_W; c++) begin
      rows.sum_row[c]   = layer_cols[NUM_STAGES][c][0];
      rows.carry_row[c] = layer_cols[NUM_STAGES][c][1];
    end
  end

endmodule

// File: design/dadda_stage.sv
`timescale 1ns/1ps

module dadda_stage import dadda_pkg::*; #(
  parameter int TARGET_HEIGHT = 2
) (
  input  col_matrix_t cols_in,
  output col_matrix_t cols_out
);

  localparam int NUM_COLS = $bits(product_t);
  localparam int COL_W    = $bits(operand_t);

  // selectors for col_plan
  localparam int PLAN_HEIGHT   = 0;
  localparam int PLAN_CARRY_IN = 1;
  localparam int PLAN_FULL     = 2;
  localparam int PLAN_HALF     = 3;

  // next lower height of the sequence 2, 3, 4, 6, 9, 13, ...
  function automatic int next_target(int d);
    int lower;
    int upper;
    lower = 1;
    upper = 2;
    while (upper < d) begin
      lower = upper;
      upper = upper * 3 / 2;
    end
    return lower;
  endfunction

  // replays all earlier layers from the raw heights, then reports
  // one figure of this layer for one column
  function automatic int col_plan(int col, int what);
    int heights [NUM_COLS];
    int target;
    int carry;
    int total;
    int full;
    int half;
    for (int c = 0; c < NUM_COLS; c++) begin
      heights[c] = dadda_col_height(c, COL_W);
    end
    target = next_target(COL_W);
    while (target >= TARGET_HEIGHT) begin
      carry = 0;
      for (int c = 0; c < NUM_COLS; c++) begin
        total = heights[c] + carry;
        full  = (total > target) ? (total - target) / 2 : 0;
        half  = (total > target) ? (total - target) % 2 : 0;
        if (target == TARGET_HEIGHT && c == col) begin
          case (what)
            PLAN_HEIGHT:   return heights[c];
            PLAN_CARRY_IN: return carry;
            PLAN_FULL:     return full;
            default:       return half;
          endcase
        end
        heights[c] = total - 2 * full - half;
        carry      = full + half;
      end
      target = next_target(target);
    end
    return 0;
  endfunction

  // carries into each column from the one below
  logic [COL_W-1:0] carries [NUM_COLS];

  assign carries[0] = '0;

  for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
    localparam int HIN  = col_plan(c, PLAN_HEIGHT);
    localparam int CIN  = col_plan(c, PLAN_CARRY_IN);
    localparam int FA   = col_plan(c, PLAN_FULL);
    localparam int HA   = col_plan(c, PLAN_HALF);
    localparam int USED = 3 * FA + 2 * HA;
    // incoming carries sit above the sums and the untouched bits
    localparam int KEPT = FA + HA + HIN - USED;

    logic [COL_W-1:0] col_bits;
    logic [COL_W-1:0] col_carry;

    always_comb begin
      col_bits  = '0;
      col_carry = '0;
      // full adders
      for (int k = 0; k < FA; k++) begin
        {col_carry[k], col_bits[k]} = cols_in[c][3*k] + cols_in[c][3*k+1]
                                    + cols_in[c][3*k+2];
      end
      // at most one half adder
      for (int k = 0; k < HA; k++) begin
        {col_carry[FA+k], col_bits[FA+k]} = cols_in[c][3*FA+2*k]
                                          + cols_in[c][3*FA+2*k+1];
      end
      for (int i = USED; i < HIN; i++) begin
        col_bits[FA+HA+i-USED] = cols_in[c][i];
      end
      for (int j = 0; j < CIN; j++) begin
        col_bits[KEPT+j] = carries[c][j];
      end
    end

    assign cols_out[c] = col_bits;

    // top column never carries out for an in-range product
    if (c < NUM_COLS - 1) begin : g_carry
      assign carries[c+1] = col_carry;
    end
  end

endmodule

// File: design/dadda_pkg.sv
`include "dadda_consts.svh"

package dadda_pkg;

  typedef logic [`DADDA_OP_W-1:0] operand_t;
  typedef logic [`DADDA_PROD_W-1:0] product_t;

  // one entry per product column, bits stacked from index 0 upward
  typedef logic [`DADDA_PROD_W-1:0][`DADDA_OP_W-1:0] col_matrix_t;

  // the two rows left after the last layer
  typedef struct packed {
    product_t sum_row;
    product_t carry_row;
  } rows_t;

  // partial product count of a column before any reduction
  function automatic int dadda_col_height(int col, int op_w);
    if (col < op_w) begin
      return col + 1;
    end
    if (col < 2 * op_w - 1) begin
      return 2 * op_w - 1 - col;
    end
    return 0;
  endfunction

endpackage

// File: design/dadda_consts.svh
`ifndef DADDA_CONSTS_SVH
`define DADDA_CONSTS_SVH

// operand and product widths
`define DADDA_OP_W 16
`define DADDA_PROD_W 32

// reduction layers
`define DADDA_NUM_STAGES 6

// target column heights, first layer first
`define DADDA_HEIGHT_1 13
`define DADDA_HEIGHT_2 9
`define DADDA_HEIGHT_3 6
`define DADDA_HEIGHT_4 4
`define DADDA_HEIGHT_5 3
`define DADDA_HEIGHT_6 2

`endif
